// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_wb_interconnect
FLIST     := wb_interconnect.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/addr_decode.sv ====
/* Slave selection from the delayed request. Strobes are combinational;
   the no-slave flag and the captured address arrive one edge later. */

module addr_decode (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_cyc,
	input  logic               i_stb,
	input  bus_pkg::bus_addr_t i_addr,
	output logic               o_ram_sel,
	output logic               o_ram_stb,
	output logic               o_bram_stb,
	output logic               o_io_stb,
	output logic               o_none_sel,
	output bus_pkg::bus_addr_t o_err_addr
);
	import bus_pkg::*;

	logic top_clear;
	logic bram_sel;
	logic io_sel;

	//////////////////////////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////////////////////////

	// Nothing lives above the RAM select bit
	assign top_clear = (i_addr[ADDR_W-1:RAM_SEL_BIT+1] == '0);

	assign o_ram_sel = top_clear && i_addr[RAM_SEL_BIT];

	// Block RAM, gaps on both sides of its select bit must be clear
	assign bram_sel = top_clear && !i_addr[RAM_SEL_BIT]
		&& i_addr[BRAM_SEL_BIT]
		&& (i_addr[RAM_SEL_BIT-1:BRAM_SEL_BIT+1] == '0)
		&& (i_addr[BRAM_SEL_BIT-1:BRAM_AW] == '0);

	// I/O block, four words at 0x100
	assign io_sel = (i_addr[ADDR_W-1:IO_SEL_BIT+1] == '0)
		&& i_addr[IO_SEL_BIT]
		&& (i_addr[IO_SEL_BIT-1:IO_AW] == '0);

	// Slave strobes
	assign o_ram_stb  = i_cyc && i_stb && o_ram_sel;
	assign o_bram_stb = i_cyc && i_stb && bram_sel;
	assign o_io_stb   = i_cyc && i_stb && io_sel;

	// Strobe that hit nothing
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_none_sel <= 1'b0;
		else
			o_none_sel <= i_cyc && i_stb && !(o_ram_sel || bram_sel || io_sel);
	end

	// Last strobed address, for the error register
	always_ff @(posedge i_clk)
	begin
		if (i_cyc && i_stb)
			o_err_addr <= i_addr;
	end

	// Map regions never overlap
	a_one_sel: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0({o_ram_sel, bram_sel, io_sel}));

endmodule

// ==== hw/block_ram.sv ====
/* Internal 1024-word memory slave. Acks one edge after each strobe and
   never stalls. Contents are undefined until written. */

module block_ram (
	input  logic                i_clk,
	input  logic                i_stb,
	input  logic                i_we,
	input  bus_pkg::bram_addr_t i_addr,
	input  bus_pkg::bus_data_t  i_data,
	output logic                o_ack,
	output bus_pkg::bus_data_t  o_data
);
	import bus_pkg::*;

	// Storage
	bus_data_t mem [0:(1<<BRAM_AW)-1];

	// Write port
	always_ff @(posedge i_clk)
	begin
		if (i_stb && i_we)
			mem[i_addr] <= i_data;
	end

	// Read returns the old word on a write
	always_ff @(posedge i_clk)
	begin
		o_data <= mem[i_addr];
	end

	// Fixed single-cycle response
	always_ff @(posedge i_clk)
	begin
		o_ack <= i_stb;
	end

endmodule

// ==== hw/bus_delay.sv ====
/* One-entry registered request stage. Holds its request while the
   downstream stall is high; dropping cyc abandons a held request. */

module bus_delay (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_wb_cyc,
	input  logic               i_wb_stb,
	input  logic               i_wb_we,
	input  bus_pkg::bus_addr_t i_wb_addr,
	input  bus_pkg::bus_data_t i_wb_data,
	input  logic               i_stall,
	output logic               o_wb_stall,
	output logic               o_cyc,
	output logic               o_stb,
	output logic               o_we,
	output bus_pkg::bus_addr_t o_addr,
	output bus_pkg::bus_data_t o_data
);

	// Stall back to master only while a request sits here
	assign o_wb_stall = o_stb && i_stall;

	// Control flags
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_cyc <= 1'b0;
			o_stb <= 1'b0;
		end
		else
		begin
			o_cyc <= i_wb_cyc;
			// Dropped cycle forgets the request
			if (!i_wb_cyc)
				o_stb <= 1'b0;
			// Advance unless held downstream
			else if (!o_wb_stall)
				o_stb <= i_wb_stb;
		end
	end

	// Payload loads on accept only and holds while idle
	always_ff @(posedge i_clk)
	begin
		if (i_wb_cyc && i_wb_stb && !o_wb_stall)
		begin
			o_we   <= i_wb_we;
			o_addr <= i_wb_addr;
			o_data <= i_wb_data;
		end
	end

	// Strobe only inside a cycle
	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_stb |-> o_cyc);

endmodule

// ==== hw/bus_pkg.sv ====
/* Address map, widths and vector types of the single-master bus.
   All addresses are word addresses. The map below assumes a 32-bit bus. */

package bus_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Slave address widths
	localparam int RAM_AW  = 26;
	localparam int BRAM_AW = 10;
	localparam int IO_AW   = 2;

	//////////////////////////////////////////////////////////////////////
	// Select bits of the address map
	//////////////////////////////////////////////////////////////////////

	// External RAM, bits 31:27 must be clear
	localparam int RAM_SEL_BIT  = 26;
	// Block RAM, only below the RAM select bit
	localparam int BRAM_SEL_BIT = 15;
	// I/O block, everything above bit 8 clear
	localparam int IO_SEL_BIT   = 8;

	// Bus vectors
	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [DATA_W-1:0] bus_data_t;

	// Slave-side addresses
	typedef logic [RAM_AW-1:0]  ram_addr_t;
	typedef logic [BRAM_AW-1:0] bram_addr_t;
	typedef logic [IO_AW-1:0]   io_addr_t;

	// Board I/O
	typedef logic [3:0] led_t;
	typedef logic [3:0] sw_t;
	typedef logic [3:0] btn_t;

endpackage

// ==== hw/io_regs.sv ====
/* Four-word I/O block: error address, LEDs, buttons and switches.
   Switch and button inputs are sampled as given, without debouncing. */

module io_regs (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_stb,
	input  logic               i_we,
	input  bus_pkg::io_addr_t  i_addr,
	input  bus_pkg::bus_data_t i_data,
	input  bus_pkg::sw_t       i_sw,
	input  bus_pkg::btn_t      i_btn,
	input  logic               i_err,
	input  bus_pkg::bus_addr_t i_err_addr,
	output logic               o_ack,
	output bus_pkg::bus_data_t o_data,
	output bus_pkg::led_t      o_led
);
	import bus_pkg::*;

	bus_addr_t err_addr_q;

	// Control state, LEDs and error address
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_ack      <= 1'b0;
			o_led      <= '0;
			err_addr_q <= '0;
		end
		else
		begin
			o_ack <= i_stb;
			// Latest bus error wins
			if (i_err)
				err_addr_q <= i_err_addr;
			// Only offset 1 is writable
			if (i_stb && i_we && (i_addr == 2'd1))
				o_led <= i_data[$bits(led_t)-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readback
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			case (i_addr)
			2'd0:    o_data <= err_addr_q;
			2'd1:    o_data <= bus_data_t'(o_led);
			// Buttons above switches
			2'd2:    o_data <= bus_data_t'({i_btn, i_sw});
			default: o_data <= '0;
			endcase
		end
	end

endmodule

// ==== hw/response_collector.sv ====
/* Merges slave responses into one registered ack or error pulse.
   Assumes responses come back in request order, one per request. */

module response_collector (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_cyc,
	input  logic               i_stb,
	input  logic               i_ram_sel,
	input  logic               i_ram_stall,
	input  logic               i_ram_ack,
	input  logic               i_ram_err,
	input  bus_pkg::bus_data_t i_ram_data,
	input  logic               i_bram_ack,
	input  bus_pkg::bus_data_t i_bram_data,
	input  logic               i_io_ack,
	input  bus_pkg::bus_data_t i_io_data,
	input  logic               i_none_sel,
	output logic               o_stall,
	output logic               o_ack,
	output logic               o_err,
	output bus_pkg::bus_data_t o_data
);

	logic any_ack;
	logic many_ack;
	logic err_now;

	// Only the external RAM can stall
	assign o_stall = i_ram_sel && i_stb && i_ram_stall;

	//////////////////////////////////////////////////////////////////////
	// Ack merge and error detection
	//////////////////////////////////////////////////////////////////////

	assign any_ack = i_ram_ack || i_bram_ack || i_io_ack;

	// Two or more slaves answering at once
	assign many_ack = (i_ram_ack && i_bram_ack)
		|| (i_ram_ack && i_io_ack)
		|| (i_bram_ack && i_io_ack);

	// Any error replaces the ack
	assign err_now = i_none_sel || i_ram_err || many_ack;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_ack <= 1'b0;
			o_err <= 1'b0;
		end
		else
		begin
			// Nothing returns once the master drops cyc
			o_ack <= i_cyc && any_ack && !err_now;
			o_err <= i_cyc && err_now;
		end
	end

	// Priority read mux, RAM first
	always_ff @(posedge i_clk)
	begin
		if (i_ram_ack)
			o_data <= i_ram_data;
		else if (i_bram_ack)
			o_data <= i_bram_data;
		else if (i_io_ack)
			o_data <= i_io_data;
	end

endmodule

// ==== hw/wb_interconnect.sv ====
/* Single-master pipelined bus with external RAM, block RAM and I/O.
   Internal slaves answer two edges after the request is accepted. */

module wb_interconnect (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_wb_cyc,
	input  logic               i_wb_stb,
	input  logic               i_wb_we,
	input  bus_pkg::bus_addr_t i_wb_addr,
	input  bus_pkg::bus_data_t i_wb_data,
	input  logic               i_ram_ack,
	input  logic               i_ram_stall,
	input  bus_pkg::bus_data_t i_ram_rdata,
	input  logic               i_ram_err,
	input  bus_pkg::sw_t       i_sw,
	input  bus_pkg::btn_t      i_btn,
	output logic               o_wb_ack,
	output logic               o_wb_stall,
	output logic               o_wb_err,
	output bus_pkg::bus_data_t o_wb_data,
	output logic               o_ram_cyc,
	output logic               o_ram_stb,
	output logic               o_ram_we,
	output bus_pkg::ram_addr_t o_ram_addr,
	output bus_pkg::bus_data_t o_ram_wdata,
	output bus_pkg::led_t      o_led
);
	import bus_pkg::*;

	// Delayed request
	logic      dly_cyc, dly_stb, dly_we;
	bus_addr_t dly_addr;
	bus_data_t dly_data;
	// Decode
	logic      ram_sel, bram_stb, io_stb, none_sel_q;
	bus_addr_t err_addr;
	// Slave responses
	logic      bram_ack, io_ack, bus_stall, err_stb;
	bus_data_t bram_data, io_data;

	bus_delay delay_stage (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .i_stall(bus_stall),
		.o_wb_stall(o_wb_stall), .o_cyc(dly_cyc), .o_stb(dly_stb),
		.o_we(dly_we), .o_addr(dly_addr), .o_data(dly_data)
	);

	addr_decode decode (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_cyc(dly_cyc), .i_stb(dly_stb), .i_addr(dly_addr),
		.o_ram_sel(ram_sel), .o_ram_stb(o_ram_stb), .o_bram_stb(bram_stb),
		.o_io_stb(io_stb), .o_none_sel(none_sel_q), .o_err_addr(err_addr)
	);

	block_ram bram (
		.i_clk(i_clk), .i_stb(bram_stb), .i_we(dly_we),
		.i_addr(dly_addr[BRAM_AW-1:0]), .i_data(dly_data),
		.o_ack(bram_ack), .o_data(bram_data)
	);

	io_regs io (
		.i_clk(i_clk), .i_reset(i_reset), .i_stb(io_stb), .i_we(dly_we),
		.i_addr(dly_addr[IO_AW-1:0]), .i_data(dly_data),
		.i_sw(i_sw), .i_btn(i_btn), .i_err(err_stb), .i_err_addr(err_addr),
		.o_ack(io_ack), .o_data(io_data), .o_led(o_led)
	);

	// Responses gated by the master's own cyc
	response_collector collect (
		.i_clk(i_clk), .i_reset(i_reset), .i_cyc(i_wb_cyc), .i_stb(dly_stb),
		.i_ram_sel(ram_sel), .i_ram_stall(i_ram_stall), .i_ram_ack(i_ram_ack),
		.i_ram_err(i_ram_err), .i_ram_data(i_ram_rdata),
		.i_bram_ack(bram_ack), .i_bram_data(bram_data),
		.i_io_ack(io_ack), .i_io_data(io_data), .i_none_sel(none_sel_q),
		.o_stall(bus_stall), .o_ack(o_wb_ack), .o_err(err_stb), .o_data(o_wb_data)
	);

	assign o_wb_err = err_stb;

	// External RAM straight from the delay stage
	assign o_ram_cyc   = dly_cyc;
	assign o_ram_we    = dly_we;
	assign o_ram_addr  = dly_addr[RAM_AW-1:0];
	assign o_ram_wdata = dly_data;

endmodule

// ==== verif/tb_wb_interconnect.sv ====
/* Directed testbench for the single-master bus interconnect.
   The external RAM model stalls and acks after random delays, in order. */

module tb_wb_interconnect;
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;

	localparam int CLK_NS = 10;
	localparam int BRAM_N = 8;
	localparam int RAM_N  = 6;
	// Up to 3 stalls and 3 ack delay cycles per RAM request plus drains
	localparam int TEST_CYCLES = 2 * BRAM_N * 4 + 2 * RAM_N * 16 + 400;

	// DUT ports
	logic      i_clk, i_reset;
	logic      i_wb_cyc, i_wb_stb, i_wb_we;
	bus_addr_t i_wb_addr;
	bus_data_t i_wb_data;
	logic      i_ram_ack = 1'b0;
	logic      i_ram_stall = 1'b0;
	logic      i_ram_err = 1'b0;
	bus_data_t i_ram_rdata = '0;
	sw_t       i_sw;
	btn_t      i_btn;
	logic      o_wb_ack, o_wb_stall, o_wb_err;
	bus_data_t o_wb_data;
	logic      o_ram_cyc, o_ram_stb, o_ram_we;
	ram_addr_t o_ram_addr;
	bus_data_t o_ram_wdata;
	led_t      o_led;

	integer      seed = 32'h4115_4f1d;
	int unsigned clk_count = 0;
	int unsigned last_acc;

	// Expected responses in request order
	bit          exp_err_q[$];
	bit          exp_read_q[$];
	bus_data_t   exp_data_q[$];
	int unsigned exp_due_q[$];

	// RAM model state
	ram_addr_t   ram_addr_q[$];
	bus_data_t   ram_mem[ram_addr_t];
	bit          ram_resp_hist[int unsigned];
	int unsigned pend_due[$];
	bit          pend_err[$];
	bus_data_t   pend_data[$];
	int unsigned next_due;
	int unsigned last_due = 0;
	int unsigned inject_at = '1;
	ram_addr_t   exp_ram_addr;
	int          stall_left = 1;
	int          stalls_made = 0;
	int          stalls_seen = 0;
	int          ram_issued = 0;
	int          ram_accepted = 0;
	int          ram_err_at = -1;

	wb_interconnect dut0 (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_NS / 2) i_clk = ~i_clk;
	end

	// Edge count read only at falling edges
	always @(posedge i_clk)
		clk_count <= clk_count + 1;

	////////////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run("A checked value was wrong");
		end
	endtask

	// Unwritten RAM words differ for every address
	function automatic bus_data_t fill_word(input ram_addr_t a);
		return {a[5:0], a} ^ 32'h5a5a_0000;
	endfunction

	////////////////////////////////////////////////////////////////////
	// External RAM model
	////////////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		i_ram_ack = 1'b0;
		i_ram_err = 1'b0;
		// Oldest pending response when due
		if (pend_due.size() != 0 && pend_due[0] <= clk_count)
		begin
			i_ram_ack   = !pend_err[0];
			i_ram_err   = pend_err[0];
			i_ram_rdata = pend_data[0];
			ram_resp_hist[clk_count] = 1'b1;
			void'(pend_due.pop_front());
			void'(pend_err.pop_front());
			void'(pend_data.pop_front());
		end
		// Stray ack for the collision test
		if (inject_at == clk_count)
		begin
			i_ram_ack = 1'b1;
			ram_resp_hist[clk_count] = 1'b1;
		end
		i_ram_stall = 1'b0;
		if (o_ram_stb === 1'b1)
		begin
			// RAM strobe only inside a RAM cycle
			check_value("o_ram_cyc", 32'(o_ram_cyc), 32'd1);
			if (stall_left > 0)
			begin
				i_ram_stall = 1'b1;
				stall_left--;
				stalls_made++;
			end
			else if (ram_addr_q.size() == 0)
				abort_run("External RAM strobed with no RAM request outstanding");
			else
			begin
				// Accepted at the coming rising edge
				exp_ram_addr = ram_addr_q.pop_front();
				check_value("o_ram_addr", 32'(o_ram_addr), 32'(exp_ram_addr));
				if (o_ram_we)
					ram_mem[o_ram_addr] = o_ram_wdata;
				if (ram_mem.exists(o_ram_addr))
					pend_data.push_back(ram_mem[o_ram_addr]);
				else
					pend_data.push_back(fill_word(o_ram_addr));
				pend_err.push_back(ram_accepted == ram_err_at);
				ram_accepted++;
				// Keep responses in order
				next_due = clk_count + 1 + ($unsigned($random(seed)) % 4);
				if (next_due <= last_due)
					next_due = last_due + 1;
				last_due = next_due;
				pend_due.push_back(next_due);
				stall_left = $unsigned($random(seed)) % 4;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Response monitor
	////////////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		if (exp_due_q.size() != 0 && exp_due_q[0] != 0 && clk_count > exp_due_q[0])
			abort_run("A fixed-latency response never arrived");
		else if (o_wb_ack === 1'b1 || o_wb_err === 1'b1)
		begin
			if (exp_err_q.size() == 0)
				abort_run("Response seen with no request outstanding");
			else
			begin
				check_value("o_wb_err", 32'(o_wb_err), 32'(exp_err_q[0]));
				check_value("o_wb_ack", 32'(o_wb_ack), 32'(!exp_err_q[0]));
				if (exp_due_q[0] != 0)
					check_value("response edge", clk_count, exp_due_q[0]);
				else
					check_value("RAM response one edge late",
						32'(ram_resp_hist.exists(clk_count - 1)), 32'd1);
				if (exp_read_q[0])
					check_value("o_wb_data", o_wb_data, exp_data_q[0]);
				void'(exp_err_q.pop_front());
				void'(exp_read_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_due_q.pop_front());
			end
		end
	end

	// Stall cycles as the master sees them
	always
	begin
		@(negedge i_clk);
		#1;
		if (o_wb_stall === 1'b1)
			stalls_seen++;
	end

	initial
	begin
		#(TEST_CYCLES * CLK_NS);
		abort_run("Timeout: the tests did not finish in time");
	end

	////////////////////////////////////////////////////////////////////
	// Master side
	////////////////////////////////////////////////////////////////////

	// Fixed latency responses are due two edges after acceptance
	task automatic issue_request(input logic we, input bus_addr_t addr,
			input bus_data_t data, input logic exp_err, input logic exp_read,
			input bus_data_t exp_data, input logic fixed_lat);
		@(negedge i_clk);
		i_wb_cyc  = 1'b1;
		i_wb_stb  = 1'b1;
		i_wb_we   = we;
		i_wb_addr = addr;
		i_wb_data = data;
		#1;
		while (o_wb_stall)
		begin
			@(negedge i_clk);
			#1;
		end
		last_acc = clk_count + 1;
		exp_err_q.push_back(exp_err);
		exp_read_q.push_back(exp_read);
		exp_data_q.push_back(exp_data);
		exp_due_q.push_back(fixed_lat ? last_acc + 2 : 32'd0);
		if (!fixed_lat)
		begin
			ram_addr_q.push_back(addr[RAM_AW-1:0]);
			ram_issued++;
		end
	endtask

	task automatic end_burst();
		@(negedge i_clk);
		i_wb_stb = 1'b0;
	endtask

	// Wait out all responses before dropping the cycle
	task automatic drain_responses();
		int n;
		n = 0;
		while (exp_err_q.size() != 0 && n < 64)
		begin
			@(negedge i_clk);
			n++;
		end
		if (exp_err_q.size() != 0)
			abort_run("Responses still outstanding after 64 cycles");
		@(negedge i_clk);
		i_wb_cyc = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////

	task automatic reset_values();
		check_value("o_wb_ack", 32'(o_wb_ack), 32'd0);
		check_value("o_wb_err", 32'(o_wb_err), 32'd0);
		check_value("o_wb_stall", 32'(o_wb_stall), 32'd0);
		check_value("o_ram_cyc", 32'(o_ram_cyc), 32'd0);
		check_value("o_ram_stb", 32'(o_ram_stb), 32'd0);
		check_value("o_led", 32'(o_led), 32'd0);
		// Error address register starts clear
		issue_request(1'b0, 32'h0000_0100, '0, 1'b0, 1'b1, 32'd0, 1'b1);
		end_burst();
		drain_responses();
	endtask

	task automatic block_ram_burst();
		bram_addr_t addrs [BRAM_N];
		bus_data_t  words [BRAM_N];
		bus_data_t  bram_ref [bram_addr_t];
		@(posedge i_clk);
		for (int i = 0; i < BRAM_N; i++)
		begin
			addrs[i] = bram_addr_t'($random(seed));
			words[i] = $random(seed);
		end
		// Back-to-back writes followed by reads
		for (int i = 0; i < BRAM_N; i++)
		begin
			bram_ref[addrs[i]] = words[i];
			issue_request(1'b1, 32'h0000_8000 | 32'(addrs[i]), words[i],
				1'b0, 1'b0, '0, 1'b1);
		end
		for (int i = 0; i < BRAM_N; i++)
			issue_request(1'b0, 32'h0000_8000 | 32'(addrs[i]), '0,
				1'b0, 1'b1, bram_ref[addrs[i]], 1'b1);
		end_burst();
		drain_responses();
	endtask

	task automatic io_register_access();
		bus_data_t sw_btn;
		sw_btn = {24'h0, i_btn, i_sw};
		issue_request(1'b1, 32'h0000_0101, 32'h0000_00a5, 1'b0, 1'b0, '0, 1'b1);
		end_burst();
		drain_responses();
		check_value("o_led", 32'(o_led), 32'h5);
		issue_request(1'b0, 32'h0000_0101, '0, 1'b0, 1'b1, 32'h5, 1'b1);
		issue_request(1'b0, 32'h0000_0102, '0, 1'b0, 1'b1, sw_btn, 1'b1);
		// Switch register is read only
		issue_request(1'b1, 32'h0000_0102, '1, 1'b0, 1'b0, '0, 1'b1);
		issue_request(1'b0, 32'h0000_0102, '0, 1'b0, 1'b1, sw_btn, 1'b1);
		issue_request(1'b0, 32'h0000_0103, '0, 1'b0, 1'b1, 32'd0, 1'b1);
		end_burst();
		drain_responses();
	endtask

	task automatic ext_ram_traffic();
		ram_addr_t addrs [RAM_N];
		bus_data_t words [RAM_N];
		bus_data_t ram_ref [ram_addr_t];
		@(posedge i_clk);
		for (int i = 0; i < RAM_N; i++)
		begin
			addrs[i] = ram_addr_t'($random(seed));
			words[i] = $random(seed);
		end
		for (int i = 0; i < RAM_N; i++)
		begin
			ram_ref[addrs[i]] = words[i];
			issue_request(1'b1, 32'h0400_0000 | 32'(addrs[i]), words[i],
				1'b0, 1'b0, '0, 1'b0);
		end
		for (int i = 0; i < RAM_N; i++)
			issue_request(1'b0, 32'h0400_0000 | 32'(addrs[i]), '0,
				1'b0, 1'b1, ram_ref[addrs[i]], 1'b0);
		end_burst();
		drain_responses();
		// Every modeled stall reached the master
		check_value("o_wb_stall cycles", stalls_seen, stalls_made);
	endtask

	task automatic error_responses();
		// Unmapped word followed by a readback of its address
		issue_request(1'b0, 32'h0000_0200, '0, 1'b1, 1'b0, '0, 1'b1);
		end_burst();
		drain_responses();
		issue_request(1'b0, 32'h0000_0100, '0, 1'b0, 1'b1, 32'h0000_0200, 1'b1);
		end_burst();
		drain_responses();
		// RAM answers with an error
		ram_err_at = ram_issued;
		issue_request(1'b0, 32'h0400_0010, '0, 1'b1, 1'b0, '0, 1'b0);
		end_burst();
		drain_responses();
		// Stray RAM ack on top of a block RAM ack
		issue_request(1'b0, 32'h0000_8004, '0, 1'b1, 1'b0, '0, 1'b1);
		inject_at = last_acc + 1;
		end_burst();
		drain_responses();
	endtask

	initial
	begin
		i_reset   = 1'b1;
		i_wb_cyc  = 1'b0;
		i_wb_stb  = 1'b0;
		i_wb_we   = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_sw      = 4'h3;
		i_btn     = 4'hc;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;

		reset_values();
		block_ram_burst();
		io_register_access();
		ext_ram_traffic();
		error_responses();

		@(negedge i_clk);
		if (exp_err_q.size() != 0 || pend_due.size() != 0)
			abort_run("Requests left without a response at the end");
		else
		begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// ==== wb_interconnect.f ====
hw/bus_pkg.sv
hw/bus_delay.sv
hw/addr_decode.sv
hw/block_ram.sv
hw/io_regs.sv
hw/response_collector.sv
hw/wb_interconnect.sv
verif/tb_wb_interconnect.sv
